/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  flags_t;

    // alu flag bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // status register fields above the flag nibble
    localparam int STATUS_IMASK = 4;
    localparam int STATUS_MODE  = 5;

    // instruction flag bits
    localparam int IR_IMM   = 11;
    localparam int IR_REV   = 10;
    localparam int IR_LOAD  = 9;
    localparam int IR_SETST = 8;

    typedef enum logic [3:0] {
        R0, R1, R2, R3, R4, R5, R6, R7, R8, R9, R10, R11, R12,
        SP, STATUS, PC
    } reg_e;

    // high nibble zero means an alu instruction
    typedef enum logic [7:0] {
        LD   = 8'h10,
        LDR  = 8'h11,
        LDI  = 8'h12,
        ST   = 8'h20,
        STR  = 8'h21,
        PUSH = 8'h30,
        POP  = 8'h31,
        INT  = 8'h40
    } opcode_e;

    typedef enum logic [3:0] {
        NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
    } cond_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, PASSA, PASSB
    } alu_op_e;

    localparam logic [3:0] VEC_HWINT  = 4'd1;
    localparam logic [3:0] VEC_SWINT  = 4'd2;
    localparam logic [3:0] VEC_EXCEPT = 4'd3;

    // first push lands on the last word of memory
    localparam word_t SP_RESET     = 32'h0000_0100;
    localparam word_t PC_RESET     = 32'd16;
    localparam word_t STATUS_RESET = 32'h0000_0010;

endpackage

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    output cpu_pkg::word_t        result,
    output cpu_pkg::flags_t       flags
);
    import cpu_pkg::*;

    logic [32:0] wide;
    logic        carry;
    logic        overflow;

    always_comb begin
        wide     = '0;
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (op)
            ADD: begin
                wide     = {1'b0, a} + {1'b0, b};
                result   = wide[31:0];
                carry    = wide[32];
                overflow = (a[31] == b[31]) && (result[31] != a[31]);
            end
            // carry set means no borrow
            SUB: begin
                wide     = {1'b0, a} + {1'b0, ~b} + 33'd1;
                result   = wide[31:0];
                carry    = wide[32];
                overflow = (a[31] != b[31]) && (result[31] != a[31]);
            end
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            SHL: begin
                result = {a[30:0], 1'b0};
                carry  = a[31];
            end
            SHR: begin
                result = {1'b0, a[31:1]};
                carry  = a[0];
            end
            PASSA: result = a;
            PASSB: result = b;
            default: result = '0;
        endcase
    end

    assign flags[FLAG_Z] = (result == '0);
    assign flags[FLAG_C] = carry;
    assign flags[FLAG_N] = result[31];
    assign flags[FLAG_V] = overflow;

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                  clk,
    input  wire                  rst,
    input  wire cpu_pkg::reg_e   sel_a_reg,
    input  wire cpu_pkg::reg_e   sel_b_reg,
    input  wire cpu_pkg::reg_e   sel_in_reg,
    input  wire                  oe_a_reg,
    input  wire                  oe_b_reg,
    input  wire                  ld_reg,
    input  wire cpu_pkg::word_t  data_in,
    input  wire                  post_inc_sp,
    input  wire                  pre_dec_sp,
    input  wire                  post_inc_pc,
    input  wire cpu_pkg::flags_t alu_flags,
    input  wire                  ld_alu_status,
    input  wire                  imask_in,
    input  wire                  ld_imask,
    input  wire                  mode_in,
    input  wire                  ld_mode,
    input  wire                  advance,
    output cpu_pkg::word_t       a_data,
    output cpu_pkg::word_t       b_data,
    output cpu_pkg::word_t       sp,
    output cpu_pkg::word_t       status
);
    import cpu_pkg::*;

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs[SP]     <= SP_RESET;
            regs[STATUS] <= STATUS_RESET;
            regs[PC]     <= PC_RESET;
        end else if (advance) begin
            if (post_inc_pc) begin
                regs[PC] <= regs[PC] + 32'd1;
            end
            if (post_inc_sp) begin
                regs[SP] <= regs[SP] + 32'd1;
            end
            if (pre_dec_sp) begin
                regs[SP] <= regs[SP] - 32'd1;
            end
            if (ld_alu_status) begin
                regs[STATUS][3:0] <= alu_flags;
            end
            if (ld_imask) begin
                regs[STATUS][STATUS_IMASK] <= imask_in;
            end
            if (ld_mode) begin
                regs[STATUS][STATUS_MODE] <= mode_in;
            end
            // last assignment, so a register load beats pointer updates
            if (ld_reg) begin
                regs[sel_in_reg] <= data_in;
            end
        end
    end

    assign a_data = oe_a_reg ? regs[sel_a_reg] : '0;
    assign b_data = oe_b_reg ? regs[sel_b_reg] : '0;
    assign sp     = regs[SP];
    assign status = regs[STATUS];

endmodule

`default_nettype wire

/* logic/control_unit.sv */
`default_nettype none

module control_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire                     hwint,
    input  wire cpu_pkg::instr_t    ir,
    input  wire cpu_pkg::word_t     status,
    input  wire                     mem_gnt,
    output logic                    mem_rd,
    output logic                    mem_wr,
    output logic                    oe_alu,
    output cpu_pkg::alu_op_e        alu_op,
    output cpu_pkg::word_t          a_reg_mask,
    output cpu_pkg::word_t          b_reg_mask,
    output cpu_pkg::reg_e           sel_a_reg,
    output cpu_pkg::reg_e           sel_b_reg,
    output cpu_pkg::reg_e           sel_in_reg,
    output logic                    oe_a_reg,
    output logic                    oe_b_reg,
    output logic                    ld_reg,
    output logic                    post_inc_sp,
    output logic                    pre_dec_sp,
    output logic                    post_inc_pc,
    output logic                    oe_a_consts,
    output logic                    oe_a_ir,
    output logic                    oe_b_ir,
    output logic                    ld_alu_status,
    output logic                    imask_in,
    output logic                    ld_imask,
    output logic                    mode_in,
    output logic                    ld_mode
);
    import cpu_pkg::*;

    localparam word_t MASK_8  = 32'h0000_00ff;
    localparam word_t MASK_16 = 32'h0000_ffff;

    // DECODE is held in the register only, cur resolves it from ir
    typedef enum logic [4:0] {
        STOP, FETCH, DECODE,
        EX_ALU, EX_LD, EX_LDR, EX_LDI, EX_ST, EX_STR, EX_PUSH, EX_POP,
        HWINT1, HWINT2, SWINT1, SWINT2, EXCEPT1, EXCEPT2
    } state_e;

    state_e state;
    state_e next_state;
    state_e cur;
    reg_e   reg_a;
    reg_e   reg_b;
    reg_e   reg_c;
    logic   int_pending;
    logic   user_status;
    logic   advance;

    function automatic logic cond_met(input cond_e c, input flags_t f);
        logic z;
        logic cy;
        logic sv;
        z  = f[FLAG_Z];
        cy = f[FLAG_C];
        sv = f[FLAG_N] ^ f[FLAG_V];
        case (c)
            EQ:      return z;
            NE:      return !z;
            LTU:     return !cy;
            GTU:     return cy && !z;
            LEU:     return !cy || z;
            GEU:     return cy;
            LTS:     return sv;
            GTS:     return !z && !sv;
            LES:     return z || sv;
            GES:     return !sv;
            default: return 1'b1;
        endcase
    endfunction

    assign reg_a       = reg_e'(ir[19:16]);
    assign reg_b       = reg_e'(ir[15:12]);
    assign reg_c       = reg_e'(ir[7:4]);
    assign int_pending = hwint && status[STATUS_IMASK];
    assign user_status = (reg_a == STATUS) && !status[STATUS_MODE];
    assign advance     = mem_gnt || !(mem_rd || mem_wr);

    // a failed condition turns the decode cycle into the next fetch
    always_comb begin
        cur = state;
        if (state == DECODE) begin
            if (!cond_met(cond_e'(ir[31:28]), status[3:0])) begin
                cur = FETCH;
            end else if (user_status && (ir[27:20] inside {LD, LDR, LDI, POP} ||
                                         (ir[27:24] == 4'h0 && ir[IR_LOAD]))) begin
                cur = EXCEPT1;
            end else if (ir[27:24] == 4'h0) begin
                cur = (ir[23:20] > PASSB) ? EXCEPT1 : EX_ALU;
            end else begin
                case (ir[27:20])
                    LD:      cur = EX_LD;
                    LDR:     cur = EX_LDR;
                    LDI:     cur = EX_LDI;
                    ST:      cur = EX_ST;
                    STR:     cur = EX_STR;
                    PUSH:    cur = EX_PUSH;
                    POP:     cur = EX_POP;
                    INT:     cur = SWINT1;
                    default: cur = EXCEPT1;
                endcase
            end
        end
    end

    always_comb begin
        next_state = state;
        if (advance) begin
            case (cur)
                STOP:    next_state = start ? FETCH : STOP;
                FETCH:   next_state = int_pending ? HWINT1 : DECODE;
                HWINT1:  next_state = HWINT2;
                SWINT1:  next_state = SWINT2;
                EXCEPT1: next_state = EXCEPT2;
                default: next_state = FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STOP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        mem_rd        = 1'b0;
        mem_wr        = 1'b0;
        oe_alu        = 1'b0;
        alu_op        = PASSA;
        a_reg_mask    = '1;
        b_reg_mask    = '1;
        sel_a_reg     = R0;
        sel_b_reg     = R0;
        sel_in_reg    = R0;
        oe_a_reg      = 1'b0;
        oe_b_reg      = 1'b0;
        ld_reg        = 1'b0;
        post_inc_sp   = 1'b0;
        pre_dec_sp    = 1'b0;
        post_inc_pc   = 1'b0;
        oe_a_consts   = 1'b0;
        oe_a_ir       = 1'b0;
        oe_b_ir       = 1'b0;
        ld_alu_status = 1'b0;
        imask_in      = 1'b0;
        ld_imask      = 1'b0;
        mode_in       = 1'b0;
        ld_mode       = 1'b0;
        case (cur)
            FETCH: begin
                // no fetch when the interrupt wins, pc stays on this instruction
                if (!int_pending) begin
                    sel_b_reg   = PC;
                    oe_b_reg    = 1'b1;
                    mem_rd      = 1'b1;
                    post_inc_pc = 1'b1;
                end
            end
            EX_ALU: begin
                if (ir[IR_IMM]) begin
                    if (ir[IR_REV]) begin
                        oe_a_ir    = 1'b1;
                        a_reg_mask = MASK_8;
                        sel_b_reg  = reg_b;
                        oe_b_reg   = 1'b1;
                    end else begin
                        sel_a_reg  = reg_b;
                        oe_a_reg   = 1'b1;
                        oe_b_ir    = 1'b1;
                        b_reg_mask = MASK_8;
                    end
                end else begin
                    sel_a_reg = ir[IR_REV] ? reg_c : reg_b;
                    sel_b_reg = ir[IR_REV] ? reg_b : reg_c;
                    oe_a_reg  = 1'b1;
                    oe_b_reg  = 1'b1;
                end
                alu_op        = alu_op_e'(ir[23:20]);
                oe_alu        = 1'b1;
                sel_in_reg    = reg_a;
                ld_reg        = ir[IR_LOAD];
                ld_alu_status = ir[IR_SETST];
            end
            EX_LD: begin
                oe_b_ir    = 1'b1;
                b_reg_mask = MASK_16;
                mem_rd     = 1'b1;
                sel_in_reg = reg_a;
                ld_reg     = 1'b1;
            end
            EX_LDR: begin
                sel_b_reg  = reg_b;
                oe_b_reg   = 1'b1;
                mem_rd     = 1'b1;
                sel_in_reg = reg_a;
                ld_reg     = 1'b1;
            end
            EX_LDI: begin
                oe_a_ir    = 1'b1;
                a_reg_mask = MASK_16;
                oe_alu     = 1'b1;
                sel_in_reg = reg_a;
                ld_reg     = 1'b1;
            end
            EX_ST: begin
                sel_a_reg  = reg_a;
                oe_a_reg   = 1'b1;
                oe_b_ir    = 1'b1;
                b_reg_mask = MASK_16;
                mem_wr     = 1'b1;
            end
            EX_STR: begin
                sel_a_reg = reg_a;
                oe_a_reg  = 1'b1;
                sel_b_reg = reg_b;
                oe_b_reg  = 1'b1;
                mem_wr    = 1'b1;
            end
            EX_PUSH: begin
                sel_a_reg  = reg_a;
                oe_a_reg   = 1'b1;
                pre_dec_sp = 1'b1;
                mem_wr     = 1'b1;
            end
            EX_POP: begin
                sel_b_reg   = SP;
                oe_b_reg    = 1'b1;
                mem_rd      = 1'b1;
                sel_in_reg  = reg_a;
                ld_reg      = 1'b1;
                post_inc_sp = 1'b1;
            end
            // return address onto the stack
            HWINT1, SWINT1, EXCEPT1: begin
                sel_a_reg  = PC;
                oe_a_reg   = 1'b1;
                pre_dec_sp = 1'b1;
                mem_wr     = 1'b1;
            end
            HWINT2, SWINT2, EXCEPT2: begin
                if (cur == HWINT2) begin
                    sel_a_reg = reg_e'(VEC_HWINT);
                end else if (cur == SWINT2) begin
                    sel_a_reg = reg_e'(VEC_SWINT);
                end else begin
                    sel_a_reg = reg_e'(VEC_EXCEPT);
                end
                oe_a_consts = 1'b1;
                oe_alu      = 1'b1;
                sel_in_reg  = PC;
                ld_reg      = 1'b1;
                // exceptions leave the mask alone
                ld_imask    = (cur != EXCEPT2);
                mode_in     = 1'b1;
                ld_mode     = 1'b1;
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) pre_dec_sp |-> !(ld_reg && mem_wr))
        else $error("stack push with both register load and memory write");

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`default_nettype none

module cpu_core #(
    parameter int ADDR_W = 8
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire                 hwint,
    output logic                cpu_rd,
    output logic                cpu_wr,
    output logic [ADDR_W-1:0]   cpu_addr,
    output cpu_pkg::word_t      cpu_wdata,
    input  wire cpu_pkg::word_t cpu_rdata,
    input  wire                 cpu_gnt
);
    import cpu_pkg::*;

    instr_t  ir_q;
    word_t   a_data;
    word_t   b_data;
    word_t   a_bus;
    word_t   b_bus;
    word_t   a_reg_mask;
    word_t   b_reg_mask;
    word_t   alu_result;
    word_t   data_in;
    word_t   sp;
    word_t   status;
    flags_t  alu_flags;
    alu_op_e alu_op;
    reg_e    sel_a_reg;
    reg_e    sel_b_reg;
    reg_e    sel_in_reg;
    logic    mem_rd;
    logic    mem_wr;
    logic    oe_alu;
    logic    oe_a_reg;
    logic    oe_b_reg;
    logic    ld_reg;
    logic    post_inc_sp;
    logic    pre_dec_sp;
    logic    post_inc_pc;
    logic    oe_a_consts;
    logic    oe_a_ir;
    logic    oe_b_ir;
    logic    ld_alu_status;
    logic    imask_in;
    logic    ld_imask;
    logic    mode_in;
    logic    ld_mode;
    logic    advance;

    control_unit u_ctrl (
        .clk, .rst, .start, .hwint,
        .ir         (ir_q),
        .status,
        .mem_gnt    (cpu_gnt),
        .mem_rd, .mem_wr, .oe_alu, .alu_op, .a_reg_mask, .b_reg_mask,
        .sel_a_reg, .sel_b_reg, .sel_in_reg, .oe_a_reg, .oe_b_reg, .ld_reg,
        .post_inc_sp, .pre_dec_sp, .post_inc_pc, .oe_a_consts, .oe_a_ir, .oe_b_ir,
        .ld_alu_status, .imask_in, .ld_imask, .mode_in, .ld_mode
    );

    reg_file u_regs (
        .clk, .rst, .sel_a_reg, .sel_b_reg, .sel_in_reg, .oe_a_reg, .oe_b_reg,
        .ld_reg, .data_in, .post_inc_sp, .pre_dec_sp, .post_inc_pc, .alu_flags,
        .ld_alu_status, .imask_in, .ld_imask, .mode_in, .ld_mode, .advance,
        .a_data, .b_data, .sp, .status
    );

    alu u_alu (
        .op     (alu_op),
        .a      (a_bus),
        .b      (b_bus),
        .result (alu_result),
        .flags  (alu_flags)
    );

    // only a granted fetch increments pc
    always_ff @(posedge clk) begin
        if (post_inc_pc && cpu_gnt) begin
            ir_q <= cpu_rdata;
        end
    end

    // register number doubles as a vector constant
    assign a_bus = (a_data
                    | (oe_a_consts ? {28'd0, sel_a_reg} : '0)
                    | (oe_a_ir ? ir_q : '0)) & a_reg_mask;
    assign b_bus = (b_data | (oe_b_ir ? ir_q : '0)) & b_reg_mask;

    assign data_in   = oe_alu ? alu_result : cpu_rdata;
    assign advance   = cpu_gnt || !(mem_rd || mem_wr);
    assign cpu_rd    = mem_rd;
    assign cpu_wr    = mem_wr;
    assign cpu_addr  = ADDR_W'(pre_dec_sp ? sp - 32'd1 : b_bus);
    assign cpu_wdata = a_bus;

    assert property (@(posedge clk) disable iff (rst) !(cpu_rd && cpu_wr))
        else $error("memory read and write requested together");

    // a stalled access must repeat unchanged
    assert property (@(posedge clk) disable iff (rst)
        (cpu_rd || cpu_wr) && !cpu_gnt |=> $stable({cpu_rd, cpu_wr, cpu_addr, cpu_wdata}))
        else $error("memory request changed while stalled");

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`default_nettype none

module mem_arbiter #(
    parameter int ADDR_W = 8
) (
    input  wire                 host_req,
    input  wire                 host_we,
    input  wire [ADDR_W-1:0]    host_addr,
    input  wire cpu_pkg::word_t host_wdata,
    input  wire                 cpu_rd,
    input  wire                 cpu_wr,
    input  wire [ADDR_W-1:0]    cpu_addr,
    input  wire cpu_pkg::word_t cpu_wdata,
    output logic                host_gnt,
    output logic                cpu_gnt,
    output logic                mem_we,
    output logic [ADDR_W-1:0]   mem_addr,
    output cpu_pkg::word_t      mem_wdata
);
    // host has fixed priority
    assign host_gnt  = host_req;
    assign cpu_gnt   = !host_req && (cpu_rd || cpu_wr);
    assign mem_we    = host_req ? host_we : cpu_wr;
    assign mem_addr  = host_req ? host_addr : cpu_addr;
    assign mem_wdata = host_req ? host_wdata : cpu_wdata;

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`default_nettype none

module data_ram #(
    parameter int ADDR_W = 8
) (
    input  wire                 clk,
    input  wire                 we,
    input  wire [ADDR_W-1:0]    addr,
    input  wire cpu_pkg::word_t wdata,
    output cpu_pkg::word_t      rdata
);
    import cpu_pkg::*;

    word_t mem [2**ADDR_W] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* logic/cpu_system.sv */
`default_nettype none

module cpu_system #(
    parameter int ADDR_W = 8
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire                 hwint,
    input  wire                 host_req,
    input  wire                 host_we,
    input  wire [ADDR_W-1:0]    host_addr,
    input  wire cpu_pkg::word_t host_wdata,
    output cpu_pkg::word_t      host_rdata,
    output logic                host_gnt
);
    import cpu_pkg::*;

    logic              cpu_rd;
    logic              cpu_wr;
    logic [ADDR_W-1:0] cpu_addr;
    word_t             cpu_wdata;
    logic              cpu_gnt;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    word_t             mem_wdata;
    word_t             mem_rdata;

    cpu_core #(.ADDR_W(ADDR_W)) u_core (
        .clk, .rst, .start, .hwint,
        .cpu_rd, .cpu_wr, .cpu_addr, .cpu_wdata,
        .cpu_rdata (mem_rdata),
        .cpu_gnt
    );

    mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .host_req, .host_we, .host_addr, .host_wdata,
        .cpu_rd, .cpu_wr, .cpu_addr, .cpu_wdata,
        .host_gnt, .cpu_gnt, .mem_we, .mem_addr, .mem_wdata
    );

    data_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk,
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // read data goes back to both requesters
    assign host_rdata = mem_rdata;

endmodule

`default_nettype wire

/* tb/cpu_system_tb.sv */
`default_nettype none

module cpu_system_tb;
    import cpu_pkg::*;

    localparam int ADDR_W      = 8;
    localparam int GNT_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 200;
    localparam int SOAK_POLLS  = 32;
    localparam int NEWLINE     = 10;

    logic              clk;
    logic              rst;
    logic              start;
    logic              hwint;
    logic              host_req;
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    word_t             host_wdata;
    word_t             host_rdata;
    logic              host_gnt;

    integer seed;
    integer fd;

    cpu_system #(.ADDR_W(ADDR_W)) uut (
        .clk, .rst, .start, .hwint,
        .host_req, .host_we, .host_addr, .host_wdata,
        .host_rdata, .host_gnt
    );

    always #20 clk = ~clk;

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst   <= 1'b1;
        start <= 1'b0;
        hwint <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // one host cycle, data sampled mid-cycle once granted
    task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                               input word_t wdata, output word_t rdata);
        int   wait_cycles;
        logic granted;
        rdata       = '0;
        granted     = 1'b0;
        wait_cycles = 0;
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        while (!granted && wait_cycles < GNT_TIMEOUT) begin
            @(negedge clk);
            if (host_gnt) begin
                granted = 1'b1;
                rdata   = host_rdata;
            end else begin
                wait_cycles++;
                @(posedge clk);
            end
        end
        assert (granted) else begin
            $display("timeout: the host port was never granted for address %02h", addr);
            stop_on_error();
        end
        @(posedge clk);
        host_req <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input word_t data);
        word_t unused;
        host_access(1'b1, addr, data, unused);
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr, output word_t data);
        host_access(1'b0, addr, '0, data);
    endtask

    // gives the core a few free cycles between polls
    task automatic idle_random();
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) @(posedge clk);
    endtask

    task automatic poll_until(input logic [ADDR_W-1:0] addr, input word_t expected,
                              output word_t got, output logic matched);
        int polls;
        polls   = 0;
        matched = 1'b0;
        got     = '0;
        while (!matched && polls < POLL_LIMIT) begin
            host_read(addr, got);
            matched = (got === expected);
            polls++;
            if (!matched) begin
                idle_random();
            end
        end
    endtask

    task automatic expect_value(input logic [ADDR_W-1:0] addr, input word_t expected);
        word_t got;
        logic  matched;
        poll_until(addr, expected, got, matched);
        assert (matched) else begin
            $display("error: %0t: address %02h expected %08h got %08h",
                     $time, addr, expected, got);
            stop_on_error();
        end
    endtask

    // hwint stays high until the next reset, the marker must not move
    task automatic hwint_marker(input logic [ADDR_W-1:0] addr, input word_t expected);
        word_t got;
        logic  matched;
        @(posedge clk);
        hwint <= 1'b1;
        poll_until(addr, expected, got, matched);
        assert (matched) else begin
            $display("timeout: the interrupt handler never wrote address %02h", addr);
            stop_on_error();
        end
        repeat (SOAK_POLLS) begin
            host_read(addr, got);
            assert (got === expected) else begin
                $display("error: %0t: address %02h expected %08h got %08h",
                         $time, addr, expected, got);
                stop_on_error();
            end
            idle_random();
        end
    endtask

    task automatic run_commands();
        logic [7:0]        cmd;
        logic [ADDR_W-1:0] addr;
        word_t             data;
        int                n;
        int                c;
        logic              done;
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                c = $fgetc(fd);
                while (c != NEWLINE && c != -1) begin
                    c = $fgetc(fd);
                end
            end else if (cmd == "S" || cmd == "R") begin
                if (cmd == "S") begin
                    pulse_start();
                end else begin
                    apply_reset();
                end
            end else begin
                n = $fscanf(fd, "%h %h", addr, data);
                assert (n == 2) else begin
                    $display("a stimulus line is missing its address or data");
                    stop_on_error();
                end
                case (cmd)
                    "W": host_write(addr, data);
                    "E": expect_value(addr, data);
                    "H": hwint_marker(addr, data);
                    default: begin
                        $display("unknown command in the stimulus file");
                        stop_on_error();
                    end
                endcase
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        hwint      = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'h0217_c9f9;
        apply_reset();
        fd = $fopen("tb/cpu_stim.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the stimulus file tb/cpu_stim.txt");
            stop_on_error();
        end
        run_commands();
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_stim.txt */
# cmd [addr data], hex: W host write, E expect value, H hwint then expect
# S start pulse, R reset; vectors and handlers stay in memory across resets
W 01 012F0040
W 02 012F0050
W 03 012F0060
# hw handler: count entries at 90, return pc to 91
W 40 01010090
W 41 00011A01
W 42 02010090
W 43 03120000
W 44 02020091
W 45 012F0045
# sw handler marker at 92
W 50 01255A5A
W 51 02050092
W 52 012F0052
# exception handler marker at 93, status at 94
W 60 0126E0E0
W 61 02060093
W 62 020E0094
W 63 012F0063
# alu program, r1 = 7, r2 = 5
W 10 01210007
W 11 01220005
W 12 00031220
W 13 00141220
W 14 00151620
W 15 00461A0F
W 16 00171E20
W 17 00583230
W 18 00394260
W 19 012A0085
W 1A 02030080
W 1B 02040081
W 1C 02050082
W 1D 02060083
W 1E 02070084
W 1F 0218A000
W 20 02090086
W 21 012F0021
S
E 86 0000000A
E 80 0000000C
E 81 00000002
E 82 FFFFFFFE
E 83 00000008
E 84 00000019
E 85 00000018
# same program again from cleared results
R
W 80 00000000
W 81 00000000
W 82 00000000
W 83 00000000
W 84 00000000
W 85 00000000
W 86 00000000
S
E 86 0000000A
E 80 0000000C
E 81 00000002
E 82 FFFFFFFE
E 83 00000008
E 84 00000019
E 85 00000018
# flags from 3 - (-2): z, c, n and v all clear
R
W 10 01210003
W 11 01230005
W 12 00121230
W 13 012400C1
W 14 00101120
W 15 120400A1
W 16 220400A2
W 17 320400A3
W 18 420400A4
W 19 520400A5
W 1A 620400A6
W 1B 720400A7
W 1C 820400A8
W 1D 920400A9
W 1E A20400AA
W 1F 020400AF
W 20 012F0020
# cells for the false conditions
W A1 0000DEAD
W A4 0000DEAD
W A6 0000DEAD
W A7 0000DEAD
W A9 0000DEAD
S
E AF 000000C1
E A1 0000DEAD
E A2 000000C1
E A3 000000C1
E A4 0000DEAD
E A5 000000C1
E A6 0000DEAD
E A7 0000DEAD
E A8 000000C1
E A9 0000DEAD
E AA 000000C1
# push three words, pop them back
R
W 10 01211111
W 11 01222222
W 12 01233333
W 13 03010000
W 14 03020000
W 15 03030000
W 16 03140000
W 17 03150000
W 18 03160000
W 19 020400B0
W 1A 020500B1
W 1B 020600B2
W 1C 020D00B3
W 1D 012F001D
S
E B3 00000100
E B0 00003333
E B1 00002222
E B2 00001111
E FF 00001111
E FE 00002222
E FD 00003333
# software interrupt
R
W 10 04000000
W FF 00000000
S
E 92 00005A5A
E FF 00000011
# ldi to status in user mode
R
W 10 012E00FF
W FF 00000000
S
E 93 0000E0E0
E 94 00000030
E FF 00000011
# hardware interrupt on a program that loops at 10
R
W 10 012F0010
W FF 00000000
S
H 90 00000001
E 91 00000010
E FF 00000010

/* filelist.f */
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/control_unit.sv
logic/cpu_core.sv
logic/mem_arbiter.sv
logic/data_ram.sv
logic/cpu_system.sv
tb/cpu_system_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = cpu_system_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = ** PASS **

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
